// ==== design/ibuf_config.svh ====
////////////////////////////////////////
// instruction buffer control constants
//   buffer depth and shift word widths
//   fill sizes for cache and bypass mode
//   full thresholds on the entry array
////////////////////////////////////////

`ifndef IBUF_CONFIG_SVH
`define IBUF_CONFIG_SVH

// number of byte entries in the buffer
`define IBUF_DEPTH 16

// one-hot consume word from the decoder, bit n means n bytes
`define IBUF_SHIFT_W 8
`define IBUF_SHIFT_AMT_W 3

// bytes delivered per fill
`define IBUF_CACHE_FILL 8
`define IBUF_BYPASS_FILL 4

// entries presented to the decoder each cycle
`define IBUF_VIEW_W 7

// entry whose valid bit raises full
`define IBUF_FULL_CACHE_IDX 8
`define IBUF_FULL_BYPASS_IDX 12

`endif

// ==== design/ibuf_pkg.sv ====
////////////////////////////////////////
// shared types for the ibuf control
//   per-entry vectors and shift words
//   fill request and entry state structs
//   decoder view and PC select enum
////////////////////////////////////////

`default_nettype none

`include "ibuf_config.svh"

package ibuf_pkg;

	// one bit per buffer entry
	typedef logic [`IBUF_DEPTH-1:0] entry_vec_t;

	typedef logic [`IBUF_SHIFT_W-1:0] shift_onehot_t;
	typedef logic [`IBUF_SHIFT_AMT_W-1:0] shift_amt_t;

	// fill request from the cache side
	typedef struct packed {
		logic       valid;
		logic       bypass;
		logic       dirty;
		// low three PC bits
		logic [2:0] offset;
	} fill_req_t;

	typedef struct packed {
		entry_vec_t valid;
		entry_vec_t dirty;
	} entry_state_t;

	// first entries as seen by the decoder
	typedef struct packed {
		logic [`IBUF_VIEW_W-1:0] vld;
		logic [`IBUF_VIEW_W-1:0] drty;
	} iu_view_t;

	// one-hot select, bit 1 is branch and bit 0 is sequential
	typedef enum logic [1:0] {
		PC_SEQ    = 2'b01,
		PC_BRANCH = 2'b10
	} pc_sel_t;

endpackage

`default_nettype wire

// ==== design/ibuf_shift_decode.sv ====
////////////////////////////////////////
// shift decoder
//   encodes the one-hot consume word
//   into a binary shift amount
////////////////////////////////////////

`default_nettype none

`include "ibuf_config.svh"

module ibuf_shift_decode
	import ibuf_pkg::*;
(
	input  shift_onehot_t shift_d,
	output shift_amt_t    shift_amt
);

	// number of set bits, needs to reach SHIFT_W
	logic [3:0] hot_cnt;
	shift_amt_t enc;

	// OR of the indices of all set bits
	always_comb begin
		hot_cnt = '0;
		enc = '0;
		for (int i = 0; i < `IBUF_SHIFT_W; i++) begin
			if (shift_d[i]) begin
				hot_cnt = hot_cnt + 4'd1;
				enc = enc | shift_amt_t'(i);
			end
		end
	end

	// only a true one-hot word gives a shift
	// zero and multi-hot words fall back to no consume
	assign shift_amt = (hot_cnt == 4'd1) ? enc : '0;

endmodule

`default_nettype wire

// ==== design/ibuf_fill_decode.sv ====
////////////////////////////////////////
// fill decoder
//   locates the first free entry
//   sizes the fill by mode and PC offset
//   produces the valid/dirty set masks
////////////////////////////////////////

`default_nettype none

`include "ibuf_config.svh"

module ibuf_fill_decode
	import ibuf_pkg::*;
(
	input  entry_state_t state,
	input  fill_req_t    fill,
	output entry_state_t fill_set
);

	// 0 to 16 valid entries
	logic [4:0] first_free;
	// 1 to 8 bytes per fill
	logic [3:0] fill_cnt;
	// one past the last entry written, may run past the top
	logic [5:0] fill_end;
	logic       fill_dirty;
	entry_vec_t fill_mask;

	// valid bits are packed from entry 0, so the count is the first hole
	always_comb begin
		first_free = '0;
		for (int i = 0; i < `IBUF_DEPTH; i++) begin
			if (state.valid[i]) begin
				first_free = first_free + 5'd1;
			end
		end
	end

	// cache fills stop at the end of the aligned double word
	assign fill_cnt = fill.bypass ? 4'(`IBUF_BYPASS_FILL) :
		4'(`IBUF_CACHE_FILL) - {1'b0, fill.offset};

	assign fill_end = {1'b0, first_free} + {2'b00, fill_cnt};

	// entries past the top of the buffer simply do not exist
	always_comb begin
		fill_mask = '0;
		for (int i = 0; i < `IBUF_DEPTH; i++) begin
			if ((6'(i) >= {1'b0, first_free}) && (6'(i) < fill_end)) begin
				fill_mask[i] = 1'b1;
			end
		end
	end

	// dirty data only comes through the bypass path
	assign fill_dirty = fill.bypass & fill.dirty;

	assign fill_set.valid = fill.valid ? fill_mask : '0;
	assign fill_set.dirty = (fill.valid && fill_dirty) ? fill_mask : '0;

endmodule

`default_nettype wire

// ==== design/ibuf_entry_array.sv ====
////////////////////////////////////////
// entry array
//   16 valid and 16 dirty flops
//   fill merge, consume shift, jump flush
////////////////////////////////////////

`default_nettype none

module ibuf_entry_array
	import ibuf_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  entry_state_t fill_set,
	input  shift_amt_t   shift_amt,
	input  logic         jmp_e,
	output entry_state_t state
);

	entry_state_t merged;
	entry_state_t next_state;

	// new fill bytes land behind the current contents
	assign merged.valid = state.valid | fill_set.valid;
	assign merged.dirty = state.dirty | fill_set.dirty;

	// consumed bytes drop off entry 0, zeros enter at the top
	// a taken jump throws everything away
	always_comb begin
		if (jmp_e) begin
			next_state = '0;
		end else begin
			next_state.valid = merged.valid >> shift_amt;
			next_state.dirty = merged.dirty >> shift_amt;
		end
	end

	// a stalled cycle with no fill and no shift keeps the state as is
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= '0;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

// ==== design/ibuf_status.sv ====
////////////////////////////////////////
// status unit
//   squash register and PC select
//   full flag and decoder view
//   registered encoded shift amount
////////////////////////////////////////

`default_nettype none

`include "ibuf_config.svh"

module ibuf_status
	import ibuf_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  entry_state_t state,
	input  logic         bypass,
	input  logic         jmp_e,
	input  shift_amt_t   shift_amt,
	output logic         full,
	output iu_view_t     view,
	output pc_sel_t      pc_sel,
	output shift_amt_t   encod_shift_e
);

	// set for the cycle after a taken jump
	logic squash;
	logic full_raw;

	always_ff @(posedge clk) begin
		if (rst) begin
			squash <= 1'b0;
			encod_shift_e <= '0;
		end else begin
			squash <= jmp_e;
			// shift amount moves to the e stage for the address adder
			encod_shift_e <= shift_amt;
		end
	end

	// a cache fill can bring 8 bytes, so stop earlier there
	assign full_raw = state.valid[`IBUF_FULL_BYPASS_IDX] |
		(!bypass & state.valid[`IBUF_FULL_CACHE_IDX]);

	// buffer is being emptied by the jump, let fetch restart
	assign full = full_raw & !squash;

	assign pc_sel = squash ? PC_BRANCH : PC_SEQ;

	assign view.vld = state.valid[`IBUF_VIEW_W-1:0];
	assign view.drty = state.dirty[`IBUF_VIEW_W-1:0];

endmodule

`default_nettype wire

// ==== design/ibuf_ctl_top.sv ====
////////////////////////////////////////
// instruction buffer control top
//   shift and fill decode
//   entry array and status unit
////////////////////////////////////////

`default_nettype none

module ibuf_ctl_top
	import ibuf_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  fill_req_t     fill,
	input  shift_onehot_t shift_d,
	input  logic          jmp_e,
	output logic          full,
	output iu_view_t      view,
	output pc_sel_t       pc_sel,
	output shift_amt_t    encod_shift_e
);

	shift_amt_t   shift_amt;
	entry_state_t fill_set;
	entry_state_t state;

	ibuf_shift_decode u_shift_decode (
		.shift_d   (shift_d),
		.shift_amt (shift_amt)
	);

	ibuf_fill_decode u_fill_decode (
		.state    (state),
		.fill     (fill),
		.fill_set (fill_set)
	);

	ibuf_entry_array u_entry_array (
		.clk       (clk),
		.rst       (rst),
		.fill_set  (fill_set),
		.shift_amt (shift_amt),
		.jmp_e     (jmp_e),
		.state     (state)
	);

	// full threshold depends on the mode of the fill in flight
	ibuf_status u_status (
		.clk           (clk),
		.rst           (rst),
		.state         (state),
		.bypass        (fill.bypass),
		.jmp_e         (jmp_e),
		.shift_amt     (shift_amt),
		.full          (full),
		.view          (view),
		.pc_sel        (pc_sel),
		.encod_shift_e (encod_shift_e)
	);

endmodule

`default_nettype wire

// ==== verif/ibuf_tb.sv ====
////////////////////////////////////////
// ibuf control testbench
//   clock, reset and LCG stimulus
//   reference model of the entry array
//   compare tasks and error summary
////////////////////////////////////////

`default_nettype none

`include "ibuf_config.svh"

module ibuf_tb
	import ibuf_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic          clk;
	logic          rst;
	fill_req_t     fill;
	shift_onehot_t shift_d;
	logic          jmp_e;
	logic          full;
	iu_view_t      view;
	pc_sel_t       pc_sel;
	shift_amt_t    encod_shift_e;

	// reference model state
	entry_vec_t m_valid;
	entry_vec_t m_dirty;
	logic       m_squash;
	shift_amt_t m_enc;

	// inputs applied at the last rising edge
	fill_req_t cur_fill;
	int        cur_shift_n;
	logic      cur_jmp;
	logic      cur_rst;

	logic [31:0] lcg_state;
	string       test_name;
	int          err_view;
	int          err_full;
	int          err_shift;
	int          err_pc;
	int          timeouts;

	ibuf_ctl_top UUT (
		.clk           (clk),
		.rst           (rst),
		.fill          (fill),
		.shift_d       (shift_d),
		.jmp_e         (jmp_e),
		.full          (full),
		.view          (view),
		.pc_sel        (pc_sel),
		.encod_shift_e (encod_shift_e)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic fill_req_t make_fill(logic v, logic b, logic d, logic [2:0] off);
		fill_req_t f;
		f.valid = v;
		f.bypass = b;
		f.dirty = d;
		f.offset = off;
		return f;
	endfunction

	// entries covered by a fill starting right behind the last valid entry
	function automatic entry_vec_t fill_entries(entry_vec_t v, fill_req_t f);
		entry_vec_t mask;
		int first;
		int bytes;
		mask = '0;
		first = 0;
		for (int i = 0; i < `IBUF_DEPTH; i++) begin
			first += int'(v[i]);
		end
		bytes = f.bypass ? `IBUF_BYPASS_FILL : `IBUF_CACHE_FILL - int'(f.offset);
		for (int k = 0; k < bytes; k++) begin
			if (first + k < `IBUF_DEPTH) begin
				mask[first + k] = 1'b1;
			end
		end
		return mask;
	endfunction

	task automatic update_model();
		entry_vec_t mask;
		entry_vec_t nv;
		entry_vec_t nd;
		mask = cur_fill.valid ? fill_entries(m_valid, cur_fill) : '0;
		nv = m_valid | mask;
		nd = m_dirty | ((cur_fill.bypass && cur_fill.dirty) ? mask : '0);
		if (cur_rst) begin
			m_valid = '0;
			m_dirty = '0;
			m_squash = 1'b0;
			m_enc = '0;
		end else begin
			m_valid = cur_jmp ? '0 : nv >> cur_shift_n;
			m_dirty = cur_jmp ? '0 : nd >> cur_shift_n;
			m_squash = cur_jmp;
			m_enc = shift_amt_t'(cur_shift_n);
		end
	endtask

	task automatic check_view(string name, iu_view_t exp, iu_view_t act);
		if (exp !== act) begin
			$display("Error %s: view expected vld=%b drty=%b, actual vld=%b drty=%b",
				name, exp.vld, exp.drty, act.vld, act.drty);
			err_view++;
		end
	endtask

	task automatic check_full(string name, logic exp, logic act);
		if (exp !== act) begin
			$display("Error %s: full expected %b, actual %b", name, exp, act);
			err_full++;
		end
	endtask

	task automatic check_shift(string name, shift_amt_t exp, shift_amt_t act);
		if (exp !== act) begin
			$display("Error %s: encod_shift_e expected %0d, actual %0d",
				name, exp, act);
			err_shift++;
		end
	endtask

	task automatic check_pc_sel(string name, pc_sel_t exp, pc_sel_t act);
		if (exp !== act) begin
			$display("Error %s: pc_sel expected %b, actual %b", name, exp, act);
			err_pc++;
		end
	endtask

	task automatic compare_outputs();
		iu_view_t exp_view;
		logic     exp_full;
		exp_view.vld = m_valid[`IBUF_VIEW_W-1:0];
		exp_view.drty = m_dirty[`IBUF_VIEW_W-1:0];
		// bypass is the fill currently on the inputs
		exp_full = (m_valid[`IBUF_FULL_BYPASS_IDX] |
			(!cur_fill.bypass & m_valid[`IBUF_FULL_CACHE_IDX])) & !m_squash;
		check_view(test_name, exp_view, view);
		check_full(test_name, exp_full, full);
		check_shift(test_name, m_enc, encod_shift_e);
		check_pc_sel(test_name, m_squash ? PC_BRANCH : PC_SEQ, pc_sel);
	endtask

	// the model takes the inputs of the previous edge while new inputs go out
	// outputs are checked mid cycle
	task automatic apply_cycle(fill_req_t f, int shift_n, logic j, logic r);
		@(posedge clk);
		update_model();
		cur_fill = f;
		cur_shift_n = shift_n;
		cur_jmp = j;
		cur_rst = r;
		fill <= f;
		shift_d <= shift_onehot_t'(32'd1 << shift_n);
		jmp_e <= j;
		rst <= r;
		@(negedge clk);
		compare_outputs();
	endtask

	task automatic wait_reset_done();
		int cnt;
		cnt = 0;
		while ((view !== '0 || pc_sel !== PC_SEQ || encod_shift_e !== '0) && cnt < 8) begin
			apply_cycle('0, 0, 1'b0, 1'b0);
			cnt++;
		end
		if (view !== '0 || pc_sel !== PC_SEQ || encod_shift_e !== '0) begin
			$display("Timeout: outputs did not reach their reset values");
			timeouts++;
		end
	endtask

	// consume 7 bytes per cycle until nothing is left
	task automatic drain_buffer();
		int cnt;
		cnt = 0;
		while ((m_valid != '0 || view.vld != '0) && cnt < 10) begin
			apply_cycle('0, 7, 1'b0, 1'b0);
			cnt++;
		end
		if (m_valid != '0 || view.vld != '0) begin
			$display("Timeout: buffer did not drain within 10 cycles");
			timeouts++;
		end
	endtask

	task automatic random_run(int cycles);
		logic [31:0] r;
		fill_req_t   f;
		for (int c = 0; c < cycles; c++) begin
			r = lcg_next();
			f = make_fill(r[16], r[17], r[18], r[21:19]);
			apply_cycle(f, int'(r[26:24]), r[30:27] == 4'd0, 1'b0);
		end
	endtask

	initial begin
		lcg_state = 32'd33;
		err_view = 0;
		err_full = 0;
		err_shift = 0;
		err_pc = 0;
		timeouts = 0;
		m_valid = '0;
		m_dirty = '0;
		m_squash = 1'b0;
		m_enc = '0;
		cur_fill = '0;
		cur_shift_n = 0;
		cur_jmp = 1'b0;
		cur_rst = 1'b1;
		fill <= '0;
		shift_d <= 8'h01;
		jmp_e <= 1'b0;
		rst <= 1'b1;

		// fill, shift and jump stay busy while rst is high
		test_name = "reset";
		repeat (4) apply_cycle(make_fill(1'b1, 1'b0, 1'b0, 3'd0), 1, 1'b1, 1'b1);
		apply_cycle('0, 0, 1'b0, 1'b0);
		wait_reset_done();
		check_view(test_name, '0, view);
		check_full(test_name, 1'b0, full);
		check_pc_sel(test_name, PC_SEQ, pc_sel);
		check_shift(test_name, '0, encod_shift_e);

		if (timeouts == 0) begin
			// offset 2 leaves six bytes in the double word
			// dirty flag without bypass marks nothing dirty
			test_name = "cache fill";
			apply_cycle(make_fill(1'b1, 1'b0, 1'b1, 3'd2), 0, 1'b0, 1'b0);
			apply_cycle('0, 0, 1'b0, 1'b0);
			check_view(test_name, {7'b0111111, 7'b0000000}, view);

			test_name = "bypass dirty fill";
			drain_buffer();
			apply_cycle(make_fill(1'b1, 1'b0, 1'b0, 3'd5), 0, 1'b0, 1'b0);
			apply_cycle(make_fill(1'b1, 1'b1, 1'b1, 3'd0), 0, 1'b0, 1'b0);
			apply_cycle('0, 0, 1'b0, 1'b0);
			check_view(test_name, {7'b1111111, 7'b1111000}, view);
		end

		if (timeouts == 0) begin
			test_name = "jump flush";
			drain_buffer();
			apply_cycle(make_fill(1'b1, 1'b0, 1'b0, 3'd0), 0, 1'b0, 1'b0);
			apply_cycle(make_fill(1'b1, 1'b0, 1'b0, 3'd0), 0, 1'b0, 1'b0);
			apply_cycle('0, 0, 1'b0, 1'b0);
			check_full(test_name, 1'b1, full);
			apply_cycle(make_fill(1'b1, 1'b1, 1'b0, 3'd0), 0, 1'b1, 1'b0);
			apply_cycle('0, 0, 1'b0, 1'b0);
			check_view(test_name, '0, view);
			check_pc_sel(test_name, PC_BRANCH, pc_sel);
			check_full(test_name, 1'b0, full);
			apply_cycle('0, 0, 1'b0, 1'b0);
			check_pc_sel(test_name, PC_SEQ, pc_sel);

			test_name = "random";
			random_run(400);
		end

		$display("errors: view %0d, full %0d, shift %0d, pc_sel %0d, timeouts %0d",
			err_view, err_full, err_shift, err_pc, timeouts);
		if (err_view + err_full + err_shift + err_pc + timeouts == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/ibuf_pkg.sv
design/ibuf_shift_decode.sv
design/ibuf_fill_decode.sv
design/ibuf_entry_array.sv
design/ibuf_status.sv
design/ibuf_ctl_top.sv
verif/ibuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the ibuf control testbench with Verilator and run it
# the result is taken from the simulation log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps \
	--top-module ibuf_tb -f list.f -Mdir obj_dir -o ibuf_sim &&
	./obj_dir/ibuf_sim > sim.log 2>&1

test -f sim.log && cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test passed" sim.log || exit 1

exit 0
